// ==== all.f ====
host_mem_rd_pkg.sv
rd_request_gen.sv
rd_response_check.sv
traffic_counters.sv
host_mem_rd_engine.sv
tb_host_mem_rd_engine.sv

// ==== host_mem_rd_engine.sv ====
// ======================================================================
// Host memory read traffic engine
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module host_mem_rd_engine
#(
    parameter int DATA_WIDTH = 512,
    parameter int BURST_CNT_WIDTH = 7
)
(
    input  wire logic                          clk,
    // Clears the engine and loads the configuration
    input  wire logic                          state_reset,
    input  wire logic                          state_run,

    // Configuration levels
    input  wire host_mem_rd_pkg::t_addr        base_addr,
    input  wire host_mem_rd_pkg::t_addr_low    start_offset,
    input  wire host_mem_rd_pkg::t_addr_low    addr_mask,
    input  wire logic [BURST_CNT_WIDTH-1:0]    burst_len,
    input  wire host_mem_rd_pkg::t_num_bursts  num_bursts,

    // Avalon read channel
    input  wire logic                          rd_waitrequest,
    input  wire logic                          rd_readdatavalid,
    input  wire logic [DATA_WIDTH-1:0]         rd_readdata,
    output logic                               rd_read,
    output host_mem_rd_pkg::t_addr             rd_address,
    output logic [BURST_CNT_WIDTH-1:0]         rd_burstcount,

    // Statistics and status
    output host_mem_rd_pkg::t_counter          rd_bursts_req,
    output host_mem_rd_pkg::t_counter          rd_lines_req,
    output host_mem_rd_pkg::t_counter          rd_lines_resp,
    output host_mem_rd_pkg::t_check            rd_data_sum,
    output host_mem_rd_pkg::t_check            rd_data_hash,
    output logic                               active
);

    // Generator to counters
    logic running;

    // ==================================================================
    // Request side
    // ==================================================================

    rd_request_gen
    #(
        .BURST_CNT_WIDTH (BURST_CNT_WIDTH)
    )
    u_req_gen
    (
        .clk            (clk),
        .state_reset    (state_reset),
        .state_run      (state_run),
        .base_addr      (base_addr),
        .start_offset   (start_offset),
        .addr_mask      (addr_mask),
        .burst_len      (burst_len),
        .num_bursts     (num_bursts),
        .rd_waitrequest (rd_waitrequest),
        .rd_read        (rd_read),
        .rd_address     (rd_address),
        .rd_burstcount  (rd_burstcount),
        .running        (running)
    );

    // ==================================================================
    // Response side
    // ==================================================================

    rd_response_check
    #(
        .DATA_WIDTH (DATA_WIDTH)
    )
    u_resp_check
    (
        .clk              (clk),
        .state_reset      (state_reset),
        .rd_readdatavalid (rd_readdatavalid),
        .rd_readdata      (rd_readdata),
        .rd_data_sum      (rd_data_sum),
        .rd_data_hash     (rd_data_hash)
    );

    // Counters watch the channel directly
    traffic_counters
    #(
        .BURST_CNT_WIDTH (BURST_CNT_WIDTH)
    )
    u_counters
    (
        .clk              (clk),
        .state_reset      (state_reset),
        .rd_read          (rd_read),
        .rd_waitrequest   (rd_waitrequest),
        .rd_burstcount    (rd_burstcount),
        .rd_readdatavalid (rd_readdatavalid),
        .running          (running),
        .rd_bursts_req    (rd_bursts_req),
        .rd_lines_req     (rd_lines_req),
        .rd_lines_resp    (rd_lines_resp),
        .active           (active)
    );

endmodule

`default_nettype wire

// ==== host_mem_rd_pkg.sv ====
// ======================================================================
// Host memory read engine shared types
// ======================================================================

`default_nettype none

package host_mem_rd_pkg;

    // ==================================================================
    // Address types
    // ==================================================================

    // Full line address as seen on the read channel
    typedef logic [63:0] t_addr;

    // Low address offset counter and its mask
    // The base is line aligned, so the offset is ORed in and never added
    typedef logic [31:0] t_addr_low;

    // ==================================================================
    // Run control and statistics
    // ==================================================================

    // Bursts per run, zero selects an unlimited run
    typedef logic [15:0] t_num_bursts;

    // Traffic counters
    typedef logic [47:0] t_counter;

    // Running sum, rotate-xor hash and the 32-bit word fed to both
    typedef logic [31:0] t_check;

    // Request generator FSM
    typedef enum logic [1:0]
    {
        REQ_IDLE,
        REQ_RUN,
        REQ_DONE
    } t_req_state;

endpackage

`default_nettype wire

// ==== rd_request_gen.sv ====
// ======================================================================
// Read burst request generator
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module rd_request_gen
#(
    parameter int BURST_CNT_WIDTH = 7
)
(
    input  wire logic                          clk,
    input  wire logic                          state_reset,
    input  wire logic                          state_run,

    // Configuration, sampled while state_reset is high
    input  wire host_mem_rd_pkg::t_addr        base_addr,
    input  wire host_mem_rd_pkg::t_addr_low    start_offset,
    input  wire host_mem_rd_pkg::t_addr_low    addr_mask,
    input  wire logic [BURST_CNT_WIDTH-1:0]    burst_len,
    input  wire host_mem_rd_pkg::t_num_bursts  num_bursts,

    // Avalon read request side
    input  wire logic                          rd_waitrequest,
    output logic                               rd_read,
    output host_mem_rd_pkg::t_addr             rd_address,
    output logic [BURST_CNT_WIDTH-1:0]         rd_burstcount,

    // High while new bursts may still be issued
    output logic                               running
);

    // ==================================================================
    // Run configuration and progress
    // ==================================================================

    host_mem_rd_pkg::t_addr        base_q;
    host_mem_rd_pkg::t_addr_low    mask_q;
    logic [BURST_CNT_WIDTH-1:0]    len_q;
    host_mem_rd_pkg::t_addr_low    offset_q;
    host_mem_rd_pkg::t_num_bursts  bursts_left;
    logic                          unlimited;
    host_mem_rd_pkg::t_req_state   state;

    logic                          req_accept;

    // Request is taken when the memory does not push back
    assign req_accept = rd_read && !rd_waitrequest;

    // ==================================================================
    // Request outputs
    // ==================================================================

    always_comb
    begin
        rd_read = (state == host_mem_rd_pkg::REQ_RUN) && state_run;
        // OR in the masked offset, base alignment keeps the bits disjoint
        rd_address = base_q | host_mem_rd_pkg::t_addr'(offset_q & mask_q);
        rd_burstcount = len_q;
    end

    assign running = rd_read;

    // ==================================================================
    // Configuration load and burst countdown
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            base_q <= base_addr;
            mask_q <= addr_mask;
            len_q <= burst_len;
            offset_q <= start_offset;
            bursts_left <= num_bursts;
            unlimited <= (num_bursts == '0);
            state <= host_mem_rd_pkg::REQ_IDLE;
        end
        else
        begin
            case (state)
                host_mem_rd_pkg::REQ_IDLE:
                begin
                    // Zero base means no read buffer, so nothing is issued
                    if (base_q == '0)
                    begin
                        state <= host_mem_rd_pkg::REQ_DONE;
                    end
                    else
                    begin
                        state <= host_mem_rd_pkg::REQ_RUN;
                    end
                end

                host_mem_rd_pkg::REQ_RUN:
                begin
                    if (req_accept)
                    begin
                        // Step to the next burst, wrap is left to the mask
                        offset_q <= offset_q + host_mem_rd_pkg::t_addr_low'(len_q);
                        bursts_left <= bursts_left - 1'b1;
                        // Last counted burst just went out
                        if (!unlimited && (bursts_left == 16'd1))
                        begin
                            state <= host_mem_rd_pkg::REQ_DONE;
                        end
                    end
                end

                // Stay done until the next reset
                default:
                begin
                    state <= host_mem_rd_pkg::REQ_DONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rd_response_check.sv ====
// ======================================================================
// Read response sum and hash
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module rd_response_check
#(
    parameter int DATA_WIDTH = 512
)
(
    input  wire logic                   clk,
    input  wire logic                   state_reset,

    // In-order read responses
    input  wire logic                   rd_readdatavalid,
    input  wire logic [DATA_WIDTH-1:0]  rd_readdata,

    // Validation results
    output host_mem_rd_pkg::t_check     rd_data_sum,
    output host_mem_rd_pkg::t_check     rd_data_hash
);

    // ==================================================================
    // Input stage
    // ==================================================================

    logic                     word_valid;
    host_mem_rd_pkg::t_check  word_q;
    host_mem_rd_pkg::t_check  hash_value;

    // Sample top and bottom 16 bits of every line
    always_ff @(posedge clk)
    begin
        word_q <= {rd_readdata[DATA_WIDTH-1 -: 16], rd_readdata[15:0]};
    end

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            word_valid <= 1'b0;
        end
        else
        begin
            word_valid <= rd_readdatavalid;
        end
    end

    // ==================================================================
    // Accumulators
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            rd_data_sum <= '0;
            hash_value <= '0;
        end
        else if (word_valid)
        begin
            // Sum wraps at 32 bits
            rd_data_sum <= rd_data_sum + word_q;
            // Rotate left by one, then fold in the new word
            hash_value <= {hash_value[30:0], hash_value[31]} ^ word_q;
        end
    end

    // Extra output stage on the hash, one cycle behind the sum
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            rd_data_hash <= '0;
        end
        else
        begin
            rd_data_hash <= hash_value;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_host_mem_rd_engine \
    -o sim_tb &&
    sim_out=$(./obj_dir/sim_tb) &&
    echo "$sim_out" &&
    echo "$sim_out" | grep -q "^Finished with no errors$" ||
    { echo "Simulation failed"; exit 1; }

// ==== tb_host_mem_rd_engine.sv ====
// ======================================================================
// Host memory read engine testbench
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_host_mem_rd_engine;

    localparam int DATA_WIDTH = 512;
    localparam int BURST_CNT_WIDTH = 7;
    // Longest run is the unlimited one of about 100 bursts of 3 lines
    // It needs well under a thousand cycles, so the limit has wide margin
    localparam int CYCLE_LIMIT = 20000;

    logic                          clk;
    logic                          state_reset;
    logic                          state_run;
    host_mem_rd_pkg::t_addr        base_addr;
    host_mem_rd_pkg::t_addr_low    start_offset;
    host_mem_rd_pkg::t_addr_low    addr_mask;
    logic [BURST_CNT_WIDTH-1:0]    burst_len;
    host_mem_rd_pkg::t_num_bursts  num_bursts;
    logic                          rd_waitrequest;
    logic                          rd_readdatavalid;
    logic [DATA_WIDTH-1:0]         rd_readdata;
    logic                          rd_read;
    host_mem_rd_pkg::t_addr        rd_address;
    logic [BURST_CNT_WIDTH-1:0]    rd_burstcount;
    host_mem_rd_pkg::t_counter     rd_bursts_req;
    host_mem_rd_pkg::t_counter     rd_lines_req;
    host_mem_rd_pkg::t_counter     rd_lines_resp;
    host_mem_rd_pkg::t_check       rd_data_sum;
    host_mem_rd_pkg::t_check       rd_data_hash;
    logic                          active;

    // ==================================================================
    // Reference model state
    // ==================================================================

    host_mem_rd_pkg::t_addr        cfg_base;
    host_mem_rd_pkg::t_addr_low    cfg_mask;
    logic [BURST_CNT_WIDTH-1:0]    cfg_len;
    host_mem_rd_pkg::t_addr_low    exp_offset;
    host_mem_rd_pkg::t_addr        exp_addr;
    host_mem_rd_pkg::t_counter     exp_bursts;
    host_mem_rd_pkg::t_counter     exp_lines_req;
    host_mem_rd_pkg::t_counter     exp_lines_resp;
    host_mem_rd_pkg::t_check       exp_sum;
    host_mem_rd_pkg::t_check       exp_hash;
    host_mem_rd_pkg::t_check       word;
    logic                          reads_allowed;

    // Memory model with one entry per line still owed
    host_mem_rd_pkg::t_addr        line_q[$];
    host_mem_rd_pkg::t_addr        line_addr;
    host_mem_rd_pkg::t_addr        line_idx;

    logic [31:0]                   rng_state;
    host_mem_rd_pkg::t_addr_low    fin_offset;
    host_mem_rd_pkg::t_addr_low    unl_offset;
    host_mem_rd_pkg::t_addr        unl_base;
    int                            cycle_count;
    int                            check_count;
    int                            error_count;

    host_mem_rd_engine
    #(
        .DATA_WIDTH      (DATA_WIDTH),
        .BURST_CNT_WIDTH (BURST_CNT_WIDTH)
    )
    u_dut
    (
        .clk              (clk),
        .state_reset      (state_reset),
        .state_run        (state_run),
        .base_addr        (base_addr),
        .start_offset     (start_offset),
        .addr_mask        (addr_mask),
        .burst_len        (burst_len),
        .num_bursts       (num_bursts),
        .rd_waitrequest   (rd_waitrequest),
        .rd_readdatavalid (rd_readdatavalid),
        .rd_readdata      (rd_readdata),
        .rd_read          (rd_read),
        .rd_address       (rd_address),
        .rd_burstcount    (rd_burstcount),
        .rd_bursts_req    (rd_bursts_req),
        .rd_lines_req     (rd_lines_req),
        .rd_lines_resp    (rd_lines_resp),
        .rd_data_sum      (rd_data_sum),
        .rd_data_hash     (rd_data_hash),
        .active           (active)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Top 16 bits carry the address and bottom 16 bits its inverse
    function automatic logic [DATA_WIDTH-1:0] make_line(input host_mem_rd_pkg::t_addr a);
        logic [DATA_WIDTH-1:0] data;
        data = '0;
        data[DATA_WIDTH-1 -: 16] = a[15:0];
        data[15:0] = ~a[15:0];
        return data;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        if (got !== expected)
        begin
            $display("Error: %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    // Load a configuration through an 8-cycle reset and clear the model
    task automatic apply_reset(input host_mem_rd_pkg::t_addr base,
                               input host_mem_rd_pkg::t_addr_low offset,
                               input host_mem_rd_pkg::t_addr_low mask,
                               input logic [BURST_CNT_WIDTH-1:0] len,
                               input host_mem_rd_pkg::t_num_bursts bursts);
        @(posedge clk);
        cfg_base = base;
        cfg_mask = mask;
        cfg_len = len;
        exp_offset = offset;
        exp_bursts = '0;
        exp_lines_req = '0;
        exp_lines_resp = '0;
        exp_sum = '0;
        exp_hash = '0;
        state_reset <= 1'b1;
        state_run <= 1'b0;
        base_addr <= base;
        start_offset <= offset;
        addr_mask <= mask;
        burst_len <= len;
        num_bursts <= bursts;
        repeat (8) @(posedge clk);
        state_reset <= 1'b0;
    endtask

    task automatic check_totals();
        check_value("rd_bursts_req", rd_bursts_req, exp_bursts);
        check_value("rd_lines_req", rd_lines_req, exp_lines_req);
        check_value("rd_lines_resp", rd_lines_resp, exp_lines_resp);
        check_value("rd_data_sum", rd_data_sum, exp_sum);
        check_value("rd_data_hash", rd_data_hash, exp_hash);
    endtask

    // Every requested line must be back once active is low
    task automatic check_drained();
        check_count++;
        if (line_q.size() != 0)
        begin
            $display("Error: active fell with %0d lines still owed", line_q.size());
            error_count++;
        end
    endtask

    // ==================================================================
    // Memory model and request checks
    // ==================================================================

    always @(posedge clk)
    begin
        rng_state = xorshift32(rng_state);
        // Push back about 30 % of cycles
        rd_waitrequest <= (rng_state % 10) < 3;
        if (rd_read && !reads_allowed)
        begin
            $display("Error: rd_read raised while no request was expected");
            error_count++;
        end
        if (rd_read && !rd_waitrequest)
        begin
            exp_addr = cfg_base | host_mem_rd_pkg::t_addr'(exp_offset & cfg_mask);
            check_value("rd_address", rd_address, exp_addr);
            check_value("rd_burstcount", 64'(rd_burstcount), 64'(cfg_len));
            for (line_idx = 0; line_idx < 64'(rd_burstcount); line_idx++)
            begin
                line_q.push_back(rd_address + line_idx);
            end
            exp_offset = exp_offset + host_mem_rd_pkg::t_addr_low'(cfg_len);
            exp_bursts = exp_bursts + 1'b1;
            exp_lines_req = exp_lines_req + host_mem_rd_pkg::t_counter'(cfg_len);
        end
        // In-order return with random gaps and at most one line per cycle
        rng_state = xorshift32(rng_state);
        if ((line_q.size() > 0) && ((rng_state % 4) != 0))
        begin
            line_addr = line_q.pop_front();
            word = {line_addr[15:0], ~line_addr[15:0]};
            rd_readdatavalid <= 1'b1;
            rd_readdata <= make_line(line_addr);
            exp_sum = exp_sum + word;
            exp_hash = {exp_hash[30:0], exp_hash[31]} ^ word;
            exp_lines_resp = exp_lines_resp + 1'b1;
        end
        else
        begin
            rd_readdatavalid <= 1'b0;
        end
    end

    // Run limit
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial
    begin
        state_reset = 1'b1;
        state_run = 1'b0;
        base_addr = '0;
        start_offset = '0;
        addr_mask = '0;
        burst_len = '0;
        num_bursts = '0;
        rd_waitrequest = 1'b0;
        rd_readdatavalid = 1'b0;
        rd_readdata = '0;
        reads_allowed = 1'b0;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        rng_state = 32'h78a02198;
        // Configuration draws happen before the first clock edge
        rng_state = xorshift32(rng_state);
        fin_offset = rng_state;
        rng_state = xorshift32(rng_state);
        unl_offset = rng_state;
        rng_state = xorshift32(rng_state);
        unl_base = {16'h0001, rng_state[15:0], 32'h0};

        // Idle after reset with the finite run already configured
        apply_reset(64'h0000_0042_0000_0000, fin_offset, 32'h0000_001f, 7'd4, 16'd12);
        repeat (10)
        begin
            @(posedge clk);
            check_value("rd_read", 64'(rd_read), 64'd0);
            check_value("active", 64'(active), 64'd0);
        end
        check_totals();

        // Finite run of 12 bursts whose 48 lines wrap the 32-line mask
        reads_allowed <= 1'b1;
        state_run <= 1'b1;
        @(posedge clk);
        while (!active) @(posedge clk);
        while (active) @(posedge clk);
        check_drained();
        reads_allowed <= 1'b0;
        repeat (20) @(posedge clk);
        check_value("rd_bursts_req", rd_bursts_req, 64'd12);
        check_value("rd_lines_req", rd_lines_req, 64'd48);
        check_value("rd_lines_resp", rd_lines_resp, 64'd48);
        check_totals();

        // Zero base address issues nothing
        apply_reset(64'h0, fin_offset, 32'h0000_001f, 7'd4, 16'd12);
        state_run <= 1'b1;
        repeat (40)
        begin
            @(posedge clk);
            check_value("active", 64'(active), 64'd0);
        end
        check_totals();

        // Unlimited run that ends when state_run drops
        apply_reset(unl_base, unl_offset, 32'h0000_ffff, 7'd3, 16'd0);
        reads_allowed <= 1'b1;
        state_run <= 1'b1;
        while (exp_bursts <= 100) @(posedge clk);
        state_run <= 1'b0;
        reads_allowed <= 1'b0;
        @(posedge clk);
        while (active) @(posedge clk);
        check_drained();
        repeat (4) @(posedge clk);
        check_count++;
        if (rd_bursts_req <= 100)
        begin
            $display("Unlimited run stopped after only %0d bursts", rd_bursts_req);
            error_count++;
        end
        check_totals();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== traffic_counters.sv ====
// ======================================================================
// Read traffic counters and activity flag
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module traffic_counters
#(
    parameter int BURST_CNT_WIDTH = 7
)
(
    input  wire logic                        clk,
    input  wire logic                        state_reset,

    // Observed read channel activity
    input  wire logic                        rd_read,
    input  wire logic                        rd_waitrequest,
    input  wire logic [BURST_CNT_WIDTH-1:0]  rd_burstcount,
    input  wire logic                        rd_readdatavalid,

    // Generator still issuing bursts
    input  wire logic                        running,

    output host_mem_rd_pkg::t_counter        rd_bursts_req,
    output host_mem_rd_pkg::t_counter        rd_lines_req,
    output host_mem_rd_pkg::t_counter        rd_lines_resp,
    output logic                             active
);

    // ==================================================================
    // Registered increment strobes
    // ==================================================================

    logic                        incr_req;
    logic [BURST_CNT_WIDTH-1:0]  incr_req_lines;
    logic                        incr_resp;

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            incr_req <= 1'b0;
            incr_req_lines <= '0;
            incr_resp <= 1'b0;
        end
        else
        begin
            incr_req <= rd_read && !rd_waitrequest;
            // Lines only count on an accepted burst
            incr_req_lines <= (rd_read && !rd_waitrequest) ? rd_burstcount : '0;
            incr_resp <= rd_readdatavalid;
        end
    end

    // ==================================================================
    // Counters
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            rd_bursts_req <= '0;
            rd_lines_req <= '0;
            rd_lines_resp <= '0;
        end
        else
        begin
            rd_bursts_req <= rd_bursts_req + host_mem_rd_pkg::t_counter'(incr_req);
            rd_lines_req <= rd_lines_req + host_mem_rd_pkg::t_counter'(incr_req_lines);
            rd_lines_resp <= rd_lines_resp + host_mem_rd_pkg::t_counter'(incr_resp);
        end
    end

    // ==================================================================
    // Activity
    // ==================================================================

    // Busy while issuing or while lines are still owed by the memory
    // A burst still in the strobe stage is not yet in rd_lines_req
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            active <= 1'b0;
        end
        else
        begin
            active <= running || incr_req || (rd_lines_req != rd_lines_resp);
        end
    end

endmodule

`default_nettype wire
